//--- files.f
hdl/mapper_pkg.sv
hdl/bank_regs.sv
hdl/cpu_map.sv
hdl/ppu_map.sv
hdl/mapper_top.sv
test/mapper_assert.sv
test/tb_mapper.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the mapper testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_mapper

output=$(./obj_dir/Vtb_mapper)
echo "$output"

# Exit status follows the pass message search
grep -qx "test passed" <<< "$output"

//--- test/tb_mapper.sv
// ------------------------------
// Mapper testbench
// Random CPU/PPU traffic against a reference model
// ------------------------------
`timescale 1ns/1ps

module tb_mapper;

	localparam int PRG_BANK_W  = 6;
	localparam int CHR_BANK_W  = 2;
	localparam int AW          = mapper_pkg::ROM_ADDR_W;
	localparam int N_TESTS     = 7;
	localparam int CYCLES      = 200; // Random cycles per test
	localparam int RST_CYCLES  = 5;
	localparam int PRELOAD     = RST_CYCLES + 4; // Bank preload before the reset test
	localparam int WATCHDOG_NS = (N_TESTS * (CYCLES + RST_CYCLES + 2) + PRELOAD) * 10 + 500;

	logic                              clk = 1'b0;
	logic                              rst;
	logic                              ce;
	mapper_pkg::mapper_e               mapper;
	logic                              mirror_vert;
	logic                              chr_ram;
	logic                              alt_nt;
	logic [mapper_pkg::CPU_ADDR_W-1:0] prg_ain;
	logic                              prg_write;
	logic [mapper_pkg::DATA_W-1:0]     prg_din;
	logic [mapper_pkg::PPU_ADDR_W-1:0] chr_ain;
	logic [AW-1:0]                     prg_aout;
	logic                              prg_allow;
	logic [AW-1:0]                     chr_aout;
	logic                              chr_allow;
	logic                              vram_ce;
	logic                              vram_a10;

	logic [PRG_BANK_W-1:0] m_prg;  // Model PRG bank
	logic [CHR_BANK_W-1:0] m_chr;  // Model CHR bank
	logic                  m_nt;   // Model 1-screen page
	logic [15:0]           lfsr;   // Stimulus generator state
	int                    checks;
	int                    errors;
	int                    test_errors;
	int                    tests_run;

	mapper_top #(
		.PRG_BANK_W (PRG_BANK_W),
		.CHR_BANK_W (CHR_BANK_W)
	) dut0 (
		.clk (clk), .rst (rst), .ce (ce), .mapper (mapper),
		.mirror_vert (mirror_vert), .chr_ram (chr_ram), .alt_nt (alt_nt),
		.prg_ain (prg_ain), .prg_write (prg_write), .prg_din (prg_din),
		.chr_ain (chr_ain), .prg_aout (prg_aout), .prg_allow (prg_allow),
		.chr_aout (chr_aout), .chr_allow (chr_allow),
		.vram_ce (vram_ce), .vram_a10 (vram_a10)
	);

	always #5 clk = ~clk; // 10 ns period

	// Galois form, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// One LFSR step per bit, MSB first
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_addr(input string name, input logic [AW-1:0] got,
	                          input logic [AW-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	// Register update for one strobe, per mapper
	task automatic model_write();
		case (mapper)
			mapper_pkg::MAP_CPROM: m_chr = prg_din[1:0];
			mapper_pkg::MAP_UNROM512: begin
				m_prg = {1'b0, prg_din[4:0]};
				m_chr = prg_din[6:5];
				m_nt  = prg_din[7];
			end
			mapper_pkg::MAP_BXROM: m_prg = prg_din[5:0];
			mapper_pkg::MAP_GXROM: begin
				m_prg = {4'b0000, prg_din[5:4]};
				m_chr = prg_din[1:0];
			end
			default: m_nt = m_nt; // NROM keeps nothing
		endcase
	endtask

	// Expected outputs from model state and current inputs
	task automatic check_outputs();
		logic          four;
		logic          one;
		logic [4:0]    bank16;
		logic [1:0]    ur_bank;
		logic [6:0]    ur_top;
		logic [AW-1:0] e_prg;
		logic [AW-1:0] e_chr;
		logic          e_a10;
		four    = (mapper == mapper_pkg::MAP_UNROM512) && alt_nt && mirror_vert;
		one     = (mapper == mapper_pkg::MAP_UNROM512) && alt_nt && !mirror_vert;
		bank16  = prg_ain[14] ? 5'b11111 : m_prg[4:0]; // Upper 16K pinned to last bank
		ur_bank = (four && chr_ain[13]) ? 2'b11 : m_chr;
		ur_top  = chr_ram ? 7'b1111111 : 7'b1000000;
		case (mapper)
			mapper_pkg::MAP_UNROM512: e_prg = {3'b000, bank16, prg_ain[13:0]};
			mapper_pkg::MAP_BXROM,
			mapper_pkg::MAP_GXROM: e_prg = {1'b0, m_prg, prg_ain[14:0]};
			default: e_prg = {7'b0000000, prg_ain[14:0]};
		endcase
		case (mapper)
			mapper_pkg::MAP_CPROM:
				e_chr = {2'b01, 6'b0, (chr_ain[12] ? m_chr : 2'b00), chr_ain[11:0]};
			mapper_pkg::MAP_GXROM: e_chr = {2'b10, 5'b0, m_chr, chr_ain[12:0]};
			mapper_pkg::MAP_UNROM512: e_chr = {ur_top, ur_bank, chr_ain[12:0]};
			default: e_chr = {2'b10, 7'b0, chr_ain[12:0]};
		endcase
		if (one)
			e_a10 = m_nt;
		else if (mirror_vert)
			e_a10 = chr_ain[10];
		else
			e_a10 = chr_ain[11];
		check_addr("prg_aout", prg_aout, e_prg);
		check_addr("chr_aout", chr_aout, e_chr);
		check_bit("prg_allow", prg_allow, prg_ain[15] && !prg_write);
		check_bit("chr_allow", chr_allow, chr_ram);
		check_bit("vram_ce", vram_ce, chr_ain[13] && !four);
		check_bit("vram_a10", vram_a10, e_a10);
	endtask

	// Header setup held while rst is high
	task automatic apply_reset(input mapper_pkg::mapper_e m, input logic mv,
	                           input logic cr, input logic an);
		@(negedge clk);
		rst         = 1'b1;
		mapper      = m;
		mirror_vert = mv;
		chr_ram     = cr;
		alt_nt      = an;
		ce          = 1'b0;
		prg_write   = 1'b0;
		prg_ain     = '0;
		prg_din     = '0;
		chr_ain     = '0;
		repeat (RST_CYCLES) begin
			@(posedge clk);
			m_prg = '0;
			m_chr = '0;
			m_nt  = 1'b0;
		end
	endtask

	// Single strobe with a fixed data byte, then a check of the new banks
	task automatic load_banks(input logic [mapper_pkg::DATA_W-1:0] d);
		@(negedge clk);
		rst       = 1'b0;
		ce        = 1'b1;
		prg_write = 1'b1;
		prg_ain   = 16'h8000;
		prg_din   = d;
		@(posedge clk);
		model_write();
		@(negedge clk);
		ce        = 1'b0;
		prg_write = 1'b0;
		#2;
		check_outputs();
	endtask

	task automatic run_test(input string name, input mapper_pkg::mapper_e m,
	                        input logic mv, input logic cr, input logic an);
		logic [31:0] r;
		test_errors = 0;
		apply_reset(m, mv, cr, an);
		for (int c = 0; c < CYCLES; c++) begin
			@(negedge clk);
			rst = 1'b0; // First pass checks zero banks
			take_bits(16, r);
			prg_ain = r[15:0];
			take_bits(8, r);
			prg_din = r[7:0];
			take_bits(14, r);
			chr_ain = r[13:0];
			take_bits(1, r);
			prg_write = r[0];
			take_bits(1, r);
			ce = r[0];
			#2;
			check_outputs();
			@(posedge clk);
			if (ce && prg_write && prg_ain[15])
				model_write(); // Strobe lands this edge
		end
		tests_run++;
		$display("%s: %0d cycles, %0d errors", name, CYCLES, test_errors);
	endtask

	initial begin
		rst = 1'b1;
		ce = 1'b0;
		mapper = mapper_pkg::MAP_NROM;
		mirror_vert = 1'b0;
		chr_ram = 1'b0;
		alt_nt = 1'b0;
		prg_ain = '0;
		prg_write = 1'b0;
		prg_din = '0;
		chr_ain = '0;
		m_prg = '0;
		m_chr = '0;
		m_nt = 1'b0;
		lfsr = 16'd59432;
		checks = 0;
		errors = 0;
		tests_run = 0;
		run_test("NROM pass-through", mapper_pkg::MAP_NROM, 1'b1, 1'b0, 1'b0);
		run_test("UNROM512 banking", mapper_pkg::MAP_UNROM512, 1'b0, 1'b1, 1'b1);
		run_test("UNROM512 four-screen", mapper_pkg::MAP_UNROM512, 1'b1, 1'b1, 1'b1);
		run_test("CPROM", mapper_pkg::MAP_CPROM, 1'b0, 1'b1, 1'b0);
		run_test("BxROM", mapper_pkg::MAP_BXROM, 1'b1, 1'b0, 1'b0);
		run_test("GxROM", mapper_pkg::MAP_GXROM, 1'b0, 1'b0, 1'b0);
		// All banks and the 1-screen page set nonzero, then they must clear
		apply_reset(mapper_pkg::MAP_UNROM512, 1'b0, 1'b0, 1'b1);
		load_banks(8'hFF);
		run_test("Reset after writes", mapper_pkg::MAP_UNROM512, 1'b0, 1'b0, 1'b1);
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Bound on total test length
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: the tests did not finish in time");
		$display("test failed");
		$finish;
	end

endmodule

//--- test/mapper_assert.sv
// ------------------------------
// Mapper top level checker
// ------------------------------
`timescale 1ns/1ps

module mapper_assert (
	input logic                clk,
	input logic                rst,
	input logic                prg_write,
	input logic                prg_allow,
	input logic                chr_allow,
	input logic                chr_ram,
	input logic                vram_ce,
	input logic                alt_nt,
	input logic                mirror_vert,
	input mapper_pkg::mapper_e mapper
);

	logic four_screen; // Cart supplies all nametables

	assign four_screen = (mapper == mapper_pkg::MAP_UNROM512) && alt_nt && mirror_vert;

	// ROM never enabled on a CPU write
	assert property (@(posedge clk) disable iff (rst) !(prg_write && prg_allow))
		else $error("prg_allow high during a CPU write");

	assert property (@(posedge clk) disable iff (rst) chr_allow == chr_ram)
		else $error("chr_allow differs from chr_ram");

	// Nametables come from CHR RAM here
	assert property (@(posedge clk) disable iff (rst) !(four_screen && vram_ce))
		else $error("vram_ce high under four-screen");

endmodule

bind mapper_top mapper_assert asrt0 (
	.clk         (clk),
	.rst         (rst),
	.prg_write   (prg_write),
	.prg_allow   (prg_allow),
	.chr_allow   (chr_allow),
	.chr_ram     (chr_ram),
	.vram_ce     (vram_ce),
	.alt_nt      (alt_nt),
	.mirror_vert (mirror_vert),
	.mapper      (mapper)
);

//--- hdl/mapper_top.sv
// ------------------------------
// Discrete mapper top level
// Bank registers feeding CPU and PPU maps
// ------------------------------
`timescale 1ns/1ps

module mapper_top #(
	parameter int PRG_BANK_W = 6, // BxROM oversize needs 6
	parameter int CHR_BANK_W = 2  // CPROM, UNROM512, GxROM use 2
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              ce,          // M2 qualifier
	input  mapper_pkg::mapper_e               mapper,      // Steady between resets
	input  logic                              mirror_vert, // Header vertical mirroring
	input  logic                              chr_ram,     // CHR is RAM
	input  logic                              alt_nt,      // Header alternate nametables
	input  logic [mapper_pkg::CPU_ADDR_W-1:0] prg_ain,     // CPU address
	input  logic                              prg_write,   // CPU write cycle
	input  logic [mapper_pkg::DATA_W-1:0]     prg_din,     // CPU write data
	input  logic [mapper_pkg::PPU_ADDR_W-1:0] chr_ain,     // PPU address
	output logic [mapper_pkg::ROM_ADDR_W-1:0] prg_aout,    // PRG ROM address
	output logic                              prg_allow,   // PRG read enable
	output logic [mapper_pkg::ROM_ADDR_W-1:0] chr_aout,    // CHR address
	output logic                              chr_allow,   // CHR write enable
	output logic                              vram_ce,     // Internal VRAM select
	output logic                              vram_a10     // VRAM A10 line
);

	logic [PRG_BANK_W-1:0] prg_bank;  // Current PRG bank
	logic [CHR_BANK_W-1:0] chr_bank;  // Current CHR bank
	logic                  nametable; // 1-screen page

	bank_regs #(
		.PRG_BANK_W (PRG_BANK_W),
		.CHR_BANK_W (CHR_BANK_W)
	) regs0 (
		.clk       (clk),
		.rst       (rst),
		.ce        (ce),
		.prg_write (prg_write),
		.mapper    (mapper),
		.prg_ain   (prg_ain),
		.prg_din   (prg_din),
		.prg_bank  (prg_bank),
		.chr_bank  (chr_bank),
		.nametable (nametable)
	);

	// CPU side, combinational
	cpu_map #(
		.PRG_BANK_W (PRG_BANK_W)
	) cmap0 (
		.mapper    (mapper),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_bank  (prg_bank),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow)
	);

	// PPU side, combinational
	ppu_map #(
		.CHR_BANK_W (CHR_BANK_W)
	) pmap0 (
		.mapper      (mapper),
		.chr_ain     (chr_ain),
		.mirror_vert (mirror_vert),
		.chr_ram     (chr_ram),
		.alt_nt      (alt_nt),
		.chr_bank    (chr_bank),
		.nametable   (nametable),
		.chr_aout    (chr_aout),
		.chr_allow   (chr_allow),
		.vram_ce     (vram_ce),
		.vram_a10    (vram_a10)
	);

endmodule

//--- hdl/ppu_map.sv
// ------------------------------
// PPU side address map
// CHR address, CHR write allow and nametable routing
// ------------------------------
`timescale 1ns/1ps

module ppu_map #(
	parameter int CHR_BANK_W = 2 // CHR bank register width
) (
	input  mapper_pkg::mapper_e               mapper,      // Active mapper number
	input  logic [mapper_pkg::PPU_ADDR_W-1:0] chr_ain,     // PPU address
	input  logic                              mirror_vert, // Header vertical mirroring
	input  logic                              chr_ram,     // CHR is RAM
	input  logic                              alt_nt,      // Header alternate nametables
	input  logic [CHR_BANK_W-1:0]             chr_bank,    // From bank_regs
	input  logic                              nametable,   // 1-screen page
	output logic [mapper_pkg::ROM_ADDR_W-1:0] chr_aout,    // CHR address
	output logic                              chr_allow,   // CHR write enable
	output logic                              vram_ce,     // Route to internal VRAM
	output logic                              vram_a10     // VRAM A10 line
);

	localparam int AW = mapper_pkg::ROM_ADDR_W;
	// Region bases with the prefix in the top two bits
	localparam logic [AW-1:0] ROM_BASE = {mapper_pkg::CHR_ROM_PREFIX, {(AW-2){1'b0}}};
	localparam logic [AW-1:0] CPR_BASE = {mapper_pkg::CPROM_PREFIX, {(AW-2){1'b0}}};

	logic                  is_unrom;    // UNROM512 selected
	logic                  four_screen; // Cart holds all four nametables
	logic                  one_screen;  // Register picks the page
	logic [CHR_BANK_W-1:0] cp_bank;     // CPROM bank, upper 4K only
	logic [1:0]            ur_bank;     // UNROM512 8K page
	logic [6:0]            ur_top;      // UNROM512 region field

	assign is_unrom    = (mapper == mapper_pkg::MAP_UNROM512);
	assign four_screen = is_unrom && alt_nt && mirror_vert;
	assign one_screen  = is_unrom && alt_nt && !mirror_vert;

	assign chr_allow = chr_ram;
	assign vram_ce   = chr_ain[13] && !four_screen; // 4-screen uses CHR RAM

	// Lower 4K pinned to bank 0
	assign cp_bank = chr_ain[12] ? chr_bank : '0;
	// Nametables at $2000 land in last CHR RAM page
	assign ur_bank = (four_screen && chr_ain[13]) ? 2'b11 : 2'(chr_bank);
	assign ur_top  = chr_ram ? mapper_pkg::CHR_RAM_PREFIX : {mapper_pkg::CHR_ROM_PREFIX, 5'b0};

	always_comb begin
		case (mapper)
			mapper_pkg::MAP_CPROM: begin
				chr_aout = CPR_BASE | AW'({cp_bank, chr_ain[11:0]}); // 4K pages
			end
			mapper_pkg::MAP_GXROM: begin
				chr_aout = ROM_BASE | AW'({chr_bank, chr_ain[12:0]}); // 8K pages
			end
			mapper_pkg::MAP_UNROM512: begin
				chr_aout = AW'({ur_top, ur_bank, chr_ain[12:0]});
			end
			default: begin
				chr_aout = ROM_BASE | AW'(chr_ain[12:0]); // NROM, BxROM fixed 8K
			end
		endcase
	end

	always_comb begin
		if (one_screen)
			vram_a10 = nametable;   // Page from register
		else if (mirror_vert)
			vram_a10 = chr_ain[10]; // Vertical, also 4-screen
		else
			vram_a10 = chr_ain[11]; // Horizontal
	end

endmodule

//--- hdl/cpu_map.sv
// ------------------------------
// CPU side address map
// CPU address to PRG ROM address and access allow
// ------------------------------
`timescale 1ns/1ps

module cpu_map #(
	parameter int PRG_BANK_W = 6 // PRG bank register width
) (
	input  mapper_pkg::mapper_e               mapper,    // Active mapper number
	input  logic [mapper_pkg::CPU_ADDR_W-1:0] prg_ain,   // CPU address
	input  logic                              prg_write, // CPU write cycle
	input  logic [PRG_BANK_W-1:0]             prg_bank,  // From bank_regs
	output logic [mapper_pkg::ROM_ADDR_W-1:0] prg_aout,  // PRG ROM address
	output logic                              prg_allow  // ROM read enable
);

	localparam int AW = mapper_pkg::ROM_ADDR_W;

	logic [4:0] bank16; // UNROM512 16K bank

	// ROM is read-only, writes only hit the registers
	assign prg_allow = prg_ain[15] && !prg_write;

	// $C000 fixed to last bank, $8000 switchable
	assign bank16 = prg_ain[14] ? mapper_pkg::FIXED_BANK : 5'(prg_bank);

	always_comb begin
		case (mapper)
			mapper_pkg::MAP_UNROM512: begin
				prg_aout = AW'({bank16, prg_ain[13:0]}); // 16K windows
			end
			mapper_pkg::MAP_BXROM,
			mapper_pkg::MAP_GXROM: begin
				prg_aout = AW'({prg_bank, prg_ain[14:0]}); // 32K windows
			end
			mapper_pkg::MAP_NROM,
			mapper_pkg::MAP_CPROM: begin
				prg_aout = AW'(prg_ain[14:0]); // Flat 32K
			end
			default: begin
				prg_aout = AW'(prg_ain[14:0]);
			end
		endcase
	end

endmodule

//--- hdl/bank_regs.sv
// ------------------------------
// Mapper bank registers
// Latches PRG/CHR banks and 1-screen select on CPU writes
// ------------------------------
`timescale 1ns/1ps

module bank_regs #(
	parameter int PRG_BANK_W = 6, // PRG bank register width
	parameter int CHR_BANK_W = 2  // CHR bank register width
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                ce,        // M2 qualifier
	input  logic                                prg_write, // CPU write cycle
	input  mapper_pkg::mapper_e                 mapper,    // Active mapper number
	input  logic [mapper_pkg::CPU_ADDR_W-1:0]   prg_ain,   // CPU address
	input  logic [mapper_pkg::DATA_W-1:0]       prg_din,   // CPU write data
	output logic [PRG_BANK_W-1:0]               prg_bank,  // To cpu_map
	output logic [CHR_BANK_W-1:0]               chr_bank,  // To ppu_map
	output logic                                nametable  // 1-screen page select
);

	logic                  wr_stb;   // Register write this cycle
	logic [PRG_BANK_W-1:0] prg_nxt;
	logic [CHR_BANK_W-1:0] chr_nxt;
	logic                  nt_nxt;

	// Any write to $8000-$FFFF during M2
	assign wr_stb = ce && prg_write && prg_ain[15];

	// Data byte decode, fields not owned by the mapper hold
	always_comb begin
		prg_nxt = prg_bank;
		chr_nxt = chr_bank;
		nt_nxt  = nametable;
		case (mapper)
			mapper_pkg::MAP_CPROM: begin
				chr_nxt = CHR_BANK_W'(prg_din[1:0]); // 4K upper pattern page
			end
			mapper_pkg::MAP_UNROM512: begin
				prg_nxt = PRG_BANK_W'(prg_din[4:0]); // 16K bank, top bits cleared
				chr_nxt = CHR_BANK_W'(prg_din[6:5]); // 8K CHR RAM page
				nt_nxt  = prg_din[7];                // 1-screen page
			end
			mapper_pkg::MAP_BXROM: begin
				prg_nxt = PRG_BANK_W'(prg_din[5:0]); // Oversize form, 2 bits official
			end
			mapper_pkg::MAP_GXROM: begin
				prg_nxt = PRG_BANK_W'(prg_din[5:4]); // 32K bank in upper nibble
				chr_nxt = CHR_BANK_W'(prg_din[1:0]); // 8K CHR bank in lower nibble
			end
			default: begin
				// NROM has no registers, writes fall through
				prg_nxt = prg_bank;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prg_bank  <= '0;
			chr_bank  <= '0;
			nametable <= 1'b0;
		end else if (wr_stb) begin
			prg_bank  <= prg_nxt; // Every strobe lands, no back-pressure
			chr_bank  <= chr_nxt;
			nametable <= nt_nxt;
		end
	end

endmodule

//--- hdl/mapper_pkg.sv
// ------------------------------
// Cartridge mapper definitions
// Bus widths, mapper numbers, region prefixes
// ------------------------------
package mapper_pkg;

	// Bus widths
	localparam int CPU_ADDR_W = 16; // CPU address bus
	localparam int PPU_ADDR_W = 14; // PPU address bus
	localparam int ROM_ADDR_W = 22; // Cartridge memory space, 4 MB
	localparam int DATA_W     = 8;  // CPU data bus

	// iNES mapper numbers handled by this core
	typedef enum logic [7:0] {
		MAP_NROM     = 8'd0,  // No mapper chip
		MAP_CPROM    = 8'd13, // 4K CHR RAM switching
		MAP_UNROM512 = 8'd30, // 16K PRG, CHR RAM banks, 1-screen
		MAP_BXROM    = 8'd34, // 32K PRG, oversize 6-bit bank
		MAP_GXROM    = 8'd66  // 32K PRG plus 8K CHR
	} mapper_e;

	// Top fields of the cartridge memory map
	// 00 PRG ROM, 10 CHR ROM, 01 CPROM CHR RAM
	localparam logic [1:0] CHR_ROM_PREFIX = 2'b10; // CHR ROM region
	localparam logic [1:0] CPROM_PREFIX   = 2'b01; // CPROM CHR RAM region

	// UNROM512 CHR RAM sits at the very top of the space
	localparam logic [6:0] CHR_RAM_PREFIX = 7'b111_1111;

	// UNROM512 fixes the last 16K bank at $C000
	localparam logic [4:0] FIXED_BANK = 5'b1_1111;

endpackage
